//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_chip_io
FILELIST    ?= verilog.f
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= --lint-only -Wall --timing
BUILD_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG    ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- chip_io.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module chip_io (
	// Clock and reset
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      rstb_pin,
	output logic                      porb_h,

	// Pad configuration chain
	input  logic                      cfg_sdi,
	input  logic                      cfg_shift,
	input  logic                      cfg_load,
	output logic                      cfg_sdo,

	// User project core side
	input  logic [`MPRJ_IO_PADS-1:0] mprj_io_out,
	output logic [`MPRJ_IO_PADS-1:0] mprj_io_in,

	// Board side of the user pads
	input  logic [`MPRJ_IO_PADS-1:0] mprj_ext,
	input  logic [`MPRJ_IO_PADS-1:0] mprj_ext_en,
	output logic [`MPRJ_IO_PADS-1:0] mprj_pad,
	output logic [`MPRJ_IO_PADS-1:0] mprj_contention
);

	// Bundled pad control shared by the chain and the pad array
	pad_ctrl_if #(
		.PADS (`MPRJ_IO_PADS)
	) pad_ctrl ();

	assign pad_ctrl.out = mprj_io_out;
	assign mprj_io_in   = pad_ctrl.in;

	// Serial pad configuration
	gpio_cfg_chain u_cfg_chain (
		.clock     (clock),
		.rst_n     (rst_n),
		.cfg_sdi   (cfg_sdi),
		.cfg_shift (cfg_shift),
		.cfg_load  (cfg_load),
		.cfg_sdo   (cfg_sdo),
		.ctrl      (pad_ctrl.cfg_src)
	);

	// User project pads
	mprj_io mprj_pads (
		.ctrl       (pad_ctrl.pad_side),
		.ext        (mprj_ext),
		.ext_en     (mprj_ext_en),
		.pad        (mprj_pad),
		.contention (mprj_contention)
	);

	// Glitch-free power-on reset from the RSTB pin
	xres_filter u_xres (
		.clock    (clock),
		.rst_n    (rst_n),
		.rstb_pin (rstb_pin),
		.porb_h   (porb_h)
	);

endmodule

//--- chip_io_chk.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module chip_io_chk (
	input logic                                      clock,
	input logic                                      rst_n,
	input logic                                      rstb_pin,
	input logic                                      porb_h,
	input logic                                      cfg_load,
	input logic [`MPRJ_IO_PADS*`PAD_CFG_BITS-1:0] pad_cfg,
	input logic [`MPRJ_IO_PADS-1:0]                 mprj_ext_en,
	input logic [`MPRJ_IO_PADS-1:0]                 mprj_contention
);

	localparam int FILTER   = `XRES_FILTER_CYCLES;
	localparam int CFG_BITS = `PAD_CFG_BITS;

	// Failed assertions, read by the testbench at the end of the run
	int assert_fails = 0;

	// Recent reset pin samples, bit 0 is the newest
	logic [FILTER+1:0] pin_hist;

	// Pads configured for a core driver, strong or open drain with output enabled
	logic [`MPRJ_IO_PADS-1:0] core_drive_cfg;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pin_hist <= '0;
		end else begin
			pin_hist <= {pin_hist[FILTER:0], rstb_pin};
		end
	end

	always_comb begin
		for (int p = 0; p < `MPRJ_IO_PADS; p++) begin
			core_drive_cfg[p] = !pad_cfg[p*CFG_BITS + 4] &&
				(pad_cfg[p*CFG_BITS +: 3] == padframe_pkg::DM_STRONG ||
				 pad_cfg[p*CFG_BITS +: 3] == padframe_pkg::DM_OPEN_DRAIN);
		end
	end

	// Two synchronizer stages plus FILTER high samples come before any release
	porb_after_stable_pin: assert property (@(posedge clock) disable iff (!rst_n)
		porb_h |-> &pin_hist[FILTER+1:2])
	else begin
		$error("porb_h high within the filter window of a low reset pin");
		assert_fails++;
	end

	cfg_change_after_load: assert property (@(posedge clock) disable iff (!rst_n)
		!$stable(pad_cfg) |-> $past(cfg_load))
	else begin
		$error("pad configuration changed without a preceding cfg_load");
		assert_fails++;
	end

	contention_needs_drivers: assert property (@(posedge clock) disable iff (!rst_n)
		(mprj_contention & ~(mprj_ext_en & core_drive_cfg)) == '0)
	else begin
		$error("contention flagged on a pad without external drive and a core driver");
		assert_fails++;
	end

endmodule

bind chip_io chip_io_chk u_chk (
	.clock           (clock),
	.rst_n           (rst_n),
	.rstb_pin        (rstb_pin),
	.porb_h          (porb_h),
	.cfg_load        (cfg_load),
	.pad_cfg         (pad_ctrl.cfg),
	.mprj_ext_en     (mprj_ext_en),
	.mprj_contention (mprj_contention)
);

//--- gpio_cfg_chain.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module gpio_cfg_chain (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        cfg_sdi,
	input  logic        cfg_shift,
	input  logic        cfg_load,
	output logic        cfg_sdo,
	pad_ctrl_if.cfg_src ctrl
);

	localparam int PADS       = `MPRJ_IO_PADS;
	localparam int CFG_BITS   = `PAD_CFG_BITS;
	localparam int CHAIN_BITS = PADS * CFG_BITS;

	// Serial chain
	// Pad p sits in bits [p*CFG_BITS +: CFG_BITS] with oeb at the top
	logic [CHAIN_BITS-1:0] chain_q;

	// Shadow copy that the pads actually use
	padframe_pkg::pad_cfg_t [PADS-1:0] active_q;

	// New bits enter at the LSB so the last bit shifted ends up in pad 0 dm[0]
	// A load in the same cycle freezes the chain
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			chain_q <= '0;
		end else if (cfg_shift && !cfg_load) begin
			chain_q <= {chain_q[CHAIN_BITS-2:0], cfg_sdi};
		end
	end

	// Transfer to the shadow on cfg_load
	// Pads only ever see complete words this way
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int p = 0; p < PADS; p++) begin
				active_q[p] <= padframe_pkg::PAD_CFG_RESET;
			end
		end else if (cfg_load) begin
			for (int p = 0; p < PADS; p++) begin
				active_q[p] <= padframe_pkg::pad_cfg_t'(chain_q[p*CFG_BITS +: CFG_BITS]);
			end
		end
	end

	// Chain MSB leaves first so images can be read back or daisy-chained
	assign cfg_sdo = chain_q[CHAIN_BITS-1];

	assign ctrl.cfg = active_q;

endmodule

//--- io_pad.sv
`timescale 1ns/1ps

module io_pad (
	input  padframe_pkg::pad_cfg_t cfg,
	input  logic                   out,
	input  logic                   ext,
	input  logic                   ext_en,
	output logic                   pad,
	output logic                   in,
	output logic                   contention
);

	logic core_en;
	logic core_val;
	logic pull_en;
	logic pull_val;

	// Core output driver
	// Open drain only ever pulls the pad low
	always_comb begin
		core_en  = 1'b0;
		core_val = 1'b0;
		if (!cfg.oeb) begin
			case (cfg.dm)
				padframe_pkg::DM_STRONG: begin
					core_en  = 1'b1;
					core_val = out;
				end
				padframe_pkg::DM_OPEN_DRAIN: begin
					core_en  = ~out;
					core_val = 1'b0;
				end
				default: begin
					core_en  = 1'b0;
					core_val = 1'b0;
				end
			endcase
		end
	end

	// Weak pull resistors apply whatever the output enable is
	always_comb begin
		case (cfg.dm)
			padframe_pkg::DM_PULLUP: begin
				pull_en  = 1'b1;
				pull_val = 1'b1;
			end
			padframe_pkg::DM_PULLDOWN: begin
				pull_en  = 1'b1;
				pull_val = 1'b0;
			end
			default: begin
				pull_en  = 1'b0;
				pull_val = 1'b0;
			end
		endcase
	end

	// Board driver wins over the core and the core wins over the pulls
	always_comb begin
		if (ext_en) begin
			pad = ext;
		end else if (core_en) begin
			pad = core_val;
		end else if (pull_en) begin
			pad = pull_val;
		end else begin
			// Floating pad reads as 0
			pad = 1'b0;
		end
	end

	// Both sides driving different levels
	assign contention = ext_en & core_en & (core_val ^ ext);

	assign in = cfg.inp_dis ? 1'b0 : pad;

endmodule

//--- mprj_io.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module mprj_io (
	pad_ctrl_if.pad_side              ctrl,
	input  logic [`MPRJ_IO_PADS-1:0] ext,
	input  logic [`MPRJ_IO_PADS-1:0] ext_en,
	output logic [`MPRJ_IO_PADS-1:0] pad,
	output logic [`MPRJ_IO_PADS-1:0] contention
);

	genvar i;

	// One pad cell per user I/O
	// Control fans out per bit and the input buffers collect back into ctrl.in
	generate
		for (i = 0; i < `MPRJ_IO_PADS; i++) begin : g_pad
			logic pad_in;

			io_pad u_pad (
				.cfg        (ctrl.cfg[i]),
				.out        (ctrl.out[i]),
				.ext        (ext[i]),
				.ext_en     (ext_en[i]),
				.pad        (pad[i]),
				.in         (pad_in),
				.contention (contention[i])
			);

			assign ctrl.in[i] = pad_in;
		end
	endgenerate

endmodule

//--- pad_ctrl_if.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

interface pad_ctrl_if #(
	parameter int PADS = `MPRJ_IO_PADS
) ();

	// Active configuration of every pad
	padframe_pkg::pad_cfg_t [PADS-1:0] cfg;

	// Core output values toward the pads
	logic [PADS-1:0] out;

	// Input buffer values back to the core
	logic [PADS-1:0] in;

	// Configuration chain side
	modport cfg_src (
		output cfg
	);

	// Pad array side
	modport pad_side (
		input  cfg,
		input  out,
		output in
	);

endinterface

//--- padframe_defs.svh
`ifndef PADFRAME_DEFS_SVH
`define PADFRAME_DEFS_SVH

// Number of user project pads in the frame
`define MPRJ_IO_PADS 8

// Configuration bits held per pad: oeb, inp_dis and a 3-bit drive mode
`define PAD_CFG_BITS 5

// Consecutive high synchronized samples needed before porb_h is released
`define XRES_FILTER_CYCLES 4

`endif

//--- padframe_pkg.sv
package padframe_pkg;

	// Drive mode codes as seen by the pad cell
	// Codes that are not listed behave as no pull and no drive
	typedef enum logic [2:0] {
		DM_HIZ        = 3'b000,
		DM_PULLDOWN   = 3'b010,
		DM_PULLUP     = 3'b011,
		DM_OPEN_DRAIN = 3'b100,
		DM_STRONG     = 3'b110
	} pad_dm_t;

	// Per-pad configuration word
	// Bit 4 is oeb, bit 3 is inp_dis and bits 2:0 are the drive mode
	typedef struct packed {
		logic    oeb;
		logic    inp_dis;
		pad_dm_t dm;
	} pad_cfg_t;

	// Safe state after reset with output off and input on
	parameter pad_cfg_t PAD_CFG_RESET = '{
		oeb:     1'b1,
		inp_dis: 1'b0,
		dm:      DM_HIZ
	};

endpackage

//--- tb_chip_io.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module tb_chip_io;

	localparam int PADS       = `MPRJ_IO_PADS;
	localparam int CFG_BITS   = `PAD_CFG_BITS;
	localparam int CHAIN_BITS = PADS * CFG_BITS;
	localparam int FILTER     = `XRES_FILTER_CYCLES;
	localparam int CLK_PERIOD = 8;
	localparam int N_ROWS     = 23;

	localparam logic [1:0] RST_NONE  = 2'd0;
	localparam logic [1:0] RST_SHORT = 2'd1;
	localparam logic [1:0] RST_LONG  = 2'd2;
	localparam logic [1:0] RST_DROP  = 2'd3;

	typedef struct packed {
		logic [CHAIN_BITS-1:0] image;
		logic [PADS-1:0]       out;
		logic [PADS-1:0]       ext;
		logic [PADS-1:0]       ext_en;
		logic [1:0]            rst_sel;
	} test_row_t;

	logic            clock;
	logic            rst_n;
	logic            rstb_pin;
	logic            cfg_sdi;
	logic            cfg_shift;
	logic            cfg_load;
	logic [PADS-1:0] mprj_io_out;
	logic [PADS-1:0] mprj_ext;
	logic [PADS-1:0] mprj_ext_en;
	logic            porb_h;
	logic            cfg_sdo;
	logic [PADS-1:0] mprj_pad;
	logic [PADS-1:0] mprj_io_in;
	logic [PADS-1:0] mprj_contention;

	test_row_t             rows [N_ROWS];
	int                    row_cnt;
	logic [31:0]           rng;
	logic [CHAIN_BITS-1:0] active_image;
	logic [CHAIN_BITS-1:0] chain_image;
	int                    errors;
	int                    passed;
	int                    failed;

	chip_io uut (
		.clock           (clock),
		.rst_n           (rst_n),
		.rstb_pin        (rstb_pin),
		.porb_h          (porb_h),
		.cfg_sdi         (cfg_sdi),
		.cfg_shift       (cfg_shift),
		.cfg_load        (cfg_load),
		.cfg_sdo         (cfg_sdo),
		.mprj_io_out     (mprj_io_out),
		.mprj_io_in      (mprj_io_in),
		.mprj_ext        (mprj_ext),
		.mprj_ext_en     (mprj_ext_en),
		.mprj_pad        (mprj_pad),
		.mprj_contention (mprj_contention)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [CFG_BITS-1:0] pad_word(input logic oeb, input logic inp_dis,
		input logic [2:0] dm);
		return {oeb, inp_dis, dm};
	endfunction

	function automatic logic [CHAIN_BITS-1:0] all_pads(input logic [CFG_BITS-1:0] word);
		return {PADS{word}};
	endfunction

	// Expected {contention, in, pad} of one pad
	function automatic logic [2:0] resolve_pad(input logic [CFG_BITS-1:0] cfg,
		input logic out, input logic ext, input logic ext_en);
		logic       drv_en;
		logic       drv_val;
		logic       level;
		logic       cont;
		logic [2:0] dm;
		dm      = cfg[2:0];
		drv_en  = 1'b0;
		drv_val = 1'b0;
		cont    = 1'b0;
		if (!cfg[4] && dm == padframe_pkg::DM_STRONG) begin
			drv_en  = 1'b1;
			drv_val = out;
		end else if (!cfg[4] && dm == padframe_pkg::DM_OPEN_DRAIN && !out) begin
			drv_en = 1'b1;
		end
		if (ext_en) begin
			level = ext;
			cont  = drv_en && (drv_val != ext);
		end else if (drv_en) begin
			level = drv_val;
		end else if (dm == padframe_pkg::DM_PULLUP) begin
			level = 1'b1;
		end else begin
			// Pull-down and a floating pad both read 0
			level = 1'b0;
		end
		return {cont, cfg[3] ? 1'b0 : level, level};
	endfunction

	task automatic check_pads(input logic [CHAIN_BITS-1:0] img);
		logic [PADS-1:0] exp_pad;
		logic [PADS-1:0] exp_in;
		logic [PADS-1:0] exp_cont;
		logic [2:0]      r;
		for (int p = 0; p < PADS; p++) begin
			r = resolve_pad(img[p*CFG_BITS +: CFG_BITS], mprj_io_out[p], mprj_ext[p],
				mprj_ext_en[p]);
			exp_cont[p] = r[2];
			exp_in[p]   = r[1];
			exp_pad[p]  = r[0];
		end
		assert (mprj_pad === exp_pad) else begin
			$display("Error: mprj_pad expected %h got %h", exp_pad, mprj_pad);
			errors++;
		end
		assert (mprj_io_in === exp_in) else begin
			$display("Error: mprj_io_in expected %h got %h", exp_in, mprj_io_in);
			errors++;
		end
		assert (mprj_contention === exp_cont) else begin
			$display("Error: mprj_contention expected %h got %h", exp_cont, mprj_contention);
			errors++;
		end
	endtask

	task automatic add_row(input logic [CHAIN_BITS-1:0] img, input logic [PADS-1:0] out,
		input logic [PADS-1:0] ext, input logic [PADS-1:0] ext_en, input logic [1:0] sel);
		rows[row_cnt] = '{img, out, ext, ext_en, sel};
		row_cnt++;
	endtask

	task automatic build_table();
		logic [CFG_BITS-1:0] s_en;
		logic [CFG_BITS-1:0] od_en;
		logic [CFG_BITS-1:0] pu_en;
		logic [CFG_BITS-1:0] pd_en;
		logic [CFG_BITS-1:0] hz_en;
		s_en  = pad_word(1'b0, 1'b0, padframe_pkg::DM_STRONG);
		od_en = pad_word(1'b0, 1'b0, padframe_pkg::DM_OPEN_DRAIN);
		pu_en = pad_word(1'b0, 1'b0, padframe_pkg::DM_PULLUP);
		pd_en = pad_word(1'b0, 1'b0, padframe_pkg::DM_PULLDOWN);
		hz_en = pad_word(1'b0, 1'b0, padframe_pkg::DM_HIZ);
		row_cnt = 0;
		add_row(all_pads(s_en), 8'hA5, 8'h00, 8'h00, RST_NONE);
		add_row(all_pads(s_en | 5'b10000), 8'hFF, 8'h3C, 8'h0F, RST_SHORT);
		add_row(all_pads(od_en), 8'h0F, 8'hFF, 8'hF0, RST_LONG);
		add_row(all_pads(od_en | 5'b10000), 8'h00, 8'h00, 8'h00, RST_NONE);
		add_row(all_pads(pu_en), 8'h00, 8'h00, 8'h01, RST_DROP);
		add_row(all_pads(pu_en | 5'b10000), 8'h55, 8'h00, 8'h00, RST_NONE);
		add_row(all_pads(pd_en), 8'hFF, 8'h80, 8'h80, RST_NONE);
		add_row(all_pads(hz_en), 8'hFF, 8'h00, 8'h00, RST_NONE);
		// Input buffers off while the core still drives
		add_row(all_pads(s_en | 5'b01000), 8'h5A, 8'h00, 8'h00, RST_NONE);
		add_row(all_pads(s_en), 8'hF0, 8'hCC, 8'hFF, RST_NONE);
		add_row({pu_en, hz_en | 5'b10000, pd_en | 5'b01000, od_en, s_en | 5'b01000,
			s_en | 5'b10000, od_en, s_en}, 8'h96, 8'h3B, 8'h21, RST_NONE);
		while (row_cnt < N_ROWS) begin
			rng = xorshift32(rng);
			rows[row_cnt].image[31:0] = rng;
			rng = xorshift32(rng);
			rows[row_cnt].image[CHAIN_BITS-1:32] = rng[CHAIN_BITS-33:0];
			rows[row_cnt].out     = rng[31:24];
			rng = xorshift32(rng);
			rows[row_cnt].ext     = rng[7:0];
			rows[row_cnt].ext_en  = rng[15:8];
			rows[row_cnt].rst_sel = rng[17:16];
			row_cnt++;
		end
	endtask

	// Shift an image in MSB first, then pulse cfg_load
	task automatic load_image(input logic [CHAIN_BITS-1:0] img);
		for (int j = CHAIN_BITS - 1; j >= 0; j--) begin
			@(posedge clock);
			cfg_shift <= 1'b1;
			cfg_sdi   <= img[j];
			@(negedge clock);
			assert (cfg_sdo === chain_image[j]) else begin
				$display("Error: cfg_sdo bit %0d expected %h got %h", j, chain_image[j], cfg_sdo);
				errors++;
			end
			check_pads(active_image);
		end
		@(posedge clock);
		cfg_shift   <= 1'b0;
		cfg_sdi     <= 1'b0;
		cfg_load    <= 1'b1;
		chain_image = img;
		@(negedge clock);
		assert (cfg_sdo === img[CHAIN_BITS-1]) else begin
			$display("Error: cfg_sdo expected %h got %h", img[CHAIN_BITS-1], cfg_sdo);
			errors++;
		end
		check_pads(active_image);
		@(posedge clock);
		cfg_load     <= 1'b0;
		active_image = img;
	endtask

	task automatic raise_porb();
		int n;
		// Hold the pin low until the synchronizer and the counter are clear
		@(posedge clock);
		rstb_pin <= 1'b0;
		repeat (3) @(posedge clock);
		rstb_pin <= 1'b1;
		n = 0;
		@(negedge clock);
		while (porb_h !== 1'b1 && n < FILTER + 6) begin
			@(posedge clock);
			n++;
			@(negedge clock);
		end
		assert (porb_h === 1'b1) else begin
			$display("porb_h never rose while the reset pin was held high");
			errors++;
		end
		// Two synchronizer edges then FILTER high samples
		assert (n == FILTER + 2) else begin
			$display("Error: porb_h rise edges expected %h got %h", FILTER + 2, n);
			errors++;
		end
	endtask

	task automatic short_pulse();
		int n;
		@(posedge clock);
		rstb_pin <= 1'b0;
		n = 0;
		@(negedge clock);
		while (porb_h !== 1'b0 && n < FILTER + 6) begin
			@(posedge clock);
			n++;
			@(negedge clock);
		end
		@(posedge clock);
		rstb_pin <= 1'b1;
		for (int k = 0; k < FILTER + 5; k++) begin
			@(posedge clock);
			if (k == FILTER - 2) begin
				rstb_pin <= 1'b0;
			end
			@(negedge clock);
			assert (porb_h === 1'b0) else begin
				$display("porb_h was released by a high pulse shorter than the filter");
				errors++;
			end
		end
	endtask

	task automatic low_pulse();
		int n;
		if (porb_h !== 1'b1) begin
			raise_porb();
		end
		@(posedge clock);
		rstb_pin <= 1'b0;
		n = 0;
		@(negedge clock);
		while (porb_h !== 1'b0 && n < FILTER + 6) begin
			@(posedge clock);
			n++;
			rstb_pin <= 1'b1;
			@(negedge clock);
		end
		assert (porb_h === 1'b0) else begin
			$display("porb_h did not drop after a low pulse on the reset pin");
			errors++;
		end
		assert (n <= 3) else begin
			$display("Error: porb_h drop edges expected %h got %h", 3, n);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			passed++;
			$display("%s: pass", name);
		end else begin
			failed++;
			$display("%s: FAIL with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic run_row(input int idx);
		int err_before;
		err_before = errors;
		load_image(rows[idx].image);
		mprj_io_out <= rows[idx].out;
		mprj_ext    <= rows[idx].ext;
		mprj_ext_en <= rows[idx].ext_en;
		@(negedge clock);
		check_pads(active_image);
		case (rows[idx].rst_sel)
			RST_SHORT: short_pulse();
			RST_LONG:  raise_porb();
			RST_DROP:  low_pulse();
			default: ;
		endcase
		report_test($sformatf("row %0d", idx), err_before);
	endtask

	initial begin
		#((N_ROWS + 1) * (CHAIN_BITS + 20) * CLK_PERIOD);
		$display("Timeout: the test rows did not finish in the expected time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int err_before;
		int total;
		clock       = 1'b0;
		rst_n       = 1'b0;
		rstb_pin    = 1'b0;
		cfg_sdi     = 1'b0;
		cfg_shift   = 1'b0;
		cfg_load    = 1'b0;
		mprj_io_out = '0;
		mprj_ext    = '0;
		mprj_ext_en = '0;
		errors      = 0;
		passed      = 0;
		failed      = 0;
		rng         = 32'd25;
		chain_image  = '0;
		active_image = all_pads(pad_word(1'b1, 1'b0, padframe_pkg::DM_HIZ));
		build_table();
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;

		// Outputs stay disabled until a configuration is loaded
		err_before = errors;
		@(posedge clock);
		mprj_io_out <= 8'hFF;
		mprj_ext    <= 8'h96;
		mprj_ext_en <= 8'h3C;
		@(negedge clock);
		check_pads(active_image);
		report_test("reset state", err_before);

		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end

		total = errors + uut.u_chk.assert_fails;
		$display("Done: %0d tests passed, %0d failed, %0d errors, %0d assertion failures",
			passed, failed, errors, uut.u_chk.assert_fails);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
padframe_pkg.sv
pad_ctrl_if.sv
io_pad.sv
mprj_io.sv
gpio_cfg_chain.sv
xres_filter.sv
chip_io.sv
chip_io_chk.sv
tb_chip_io.sv

//--- xres_filter.sv
`timescale 1ns/1ps
`include "padframe_defs.svh"

module xres_filter (
	input  logic clock,
	input  logic rst_n,
	input  logic rstb_pin,
	output logic porb_h
);

	localparam int FILTER_CYCLES = `XRES_FILTER_CYCLES;
	localparam int CNT_W = ($clog2(FILTER_CYCLES) > 0) ? $clog2(FILTER_CYCLES) : 1;

	logic [1:0]       sync_q;
	logic [CNT_W-1:0] high_cnt_q;

	// Two-stage synchronizer for the asynchronous pin
	// Starts low so the chip stays in reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], rstb_pin};
		end
	end

	// Count consecutive high samples and saturate at FILTER_CYCLES-1
	// A single low sample restarts the count and pulls porb_h down
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			high_cnt_q <= '0;
			porb_h     <= 1'b0;
		end else if (!sync_q[1]) begin
			high_cnt_q <= '0;
			porb_h     <= 1'b0;
		end else if (high_cnt_q == CNT_W'(FILTER_CYCLES - 1)) begin
			porb_h <= 1'b1;
		end else begin
			high_cnt_q <= high_cnt_q + 1'b1;
		end
	end

endmodule
